//--- verilog/lcd_cmd_pkg.sv
package lcd_cmd_pkg;

    // ------------------------------------------------------------
    // ILI9341 opcodes used by the power-up script
    // ------------------------------------------------------------
    typedef enum logic [7:0] {
        cmd_swreset   = 8'h01,  // Software reset
        cmd_slpout    = 8'h11,  // Sleep out
        cmd_gammaset  = 8'h26,
        cmd_dispon    = 8'h29,  // Display on
        cmd_caset     = 8'h2A,  // Column address set
        cmd_paset     = 8'h2B,  // Page address set
        cmd_ramwr     = 8'h2C,  // Memory write
        cmd_madctl    = 8'h36,  // Memory access control
        cmd_vscradd   = 8'h37,
        cmd_colmod    = 8'h3A,  // Pixel format
        cmd_frmcrn1   = 8'hB1,  // Frame rate, normal mode
        cmd_disctrl   = 8'hB6,
        cmd_pwctr1    = 8'hC0,
        cmd_pwctr2    = 8'hC1,
        cmd_vmctr1    = 8'hC5,  // VCOM control 1
        cmd_vmctr2    = 8'hC7,  // VCOM control 2
        cmd_powera    = 8'hCB,
        cmd_powerb    = 8'hCF,
        cmd_dtca      = 8'hE8,  // Driver timing A
        cmd_dtcb      = 8'hEA,  // Driver timing B
        cmd_power_seq = 8'hED,
        cmd_gamma3_en = 8'hF2,
        cmd_prc       = 8'hF7   // Pump ratio
    } lcd_cmd_t;

    // MADCTL rotation and colour order bits
    localparam logic [7:0] madctl_my  = 8'h80;
    localparam logic [7:0] madctl_mx  = 8'h40;
    localparam logic [7:0] madctl_mv  = 8'h20;
    localparam logic [7:0] madctl_bgr = 8'h08;

    // ------------------------------------------------------------
    // Script segment boundaries
    // ------------------------------------------------------------
    localparam logic [6:0] script_len   = 7'd66;
    localparam logic [6:0] cfg_first    = 7'd1;   // After SWRESET
    localparam logic [6:0] cfg_last     = 7'd51;  // SLPOUT closes the block
    localparam logic [6:0] dispon_idx   = 7'd52;
    localparam logic [6:0] window_first = 7'd53;  // MADCTL
    localparam logic [6:0] script_last  = script_len - 7'd1;  // RAMWR

endpackage

//--- verilog/lcd_ctrl_pkg.sv
package lcd_ctrl_pkg;

    localparam int byte_bits  = 8;
    localparam int idx_bits   = 7;
    localparam int pixel_bits = 16;

    typedef logic [idx_bits-1:0]   script_idx_t;
    typedef logic [pixel_bits-1:0] pixel_t;  // RGB565

    typedef struct packed {
        logic                 dc;    // 0 command, 1 data
        logic [byte_bits-1:0] data;
    } spi_word_t;

    typedef struct packed {
        logic      start;  // Only valid while idle is high
        spi_word_t word;
    } spi_req_t;

    typedef enum logic [3:0] {
        start,
        send_reset,
        wait_reset,
        send_config,
        wait_config,
        send_dispon,
        wait_dispon,
        send_window,
        frame_loop,
        wait_frame
    } seq_state_t;

endpackage

//--- verilog/init_rom.sv
`timescale 1ns/1ps

module init_rom (
    input  lcd_ctrl_pkg::script_idx_t script_idx,
    output lcd_ctrl_pkg::spi_word_t   script_word
);
    import lcd_cmd_pkg::*;
    import lcd_ctrl_pkg::*;

    function automatic spi_word_t op(input lcd_cmd_t code);
        return '{dc: 1'b0, data: code};
    endfunction

    function automatic spi_word_t arg(input logic [byte_bits-1:0] value);
        return '{dc: 1'b1, data: value};
    endfunction

    always_comb begin
        case (script_idx)
            7'd0:  script_word = op(cmd_swreset);
            // ------------------------------------------------------------
            // Configuration block, no gamma tables
            // ------------------------------------------------------------
            7'd1:  script_word = op(cmd_powera);
            7'd2:  script_word = arg(8'h39);
            7'd3:  script_word = arg(8'h2C);
            7'd4:  script_word = arg(8'h00);
            7'd5:  script_word = arg(8'h34);
            7'd6:  script_word = arg(8'h02);
            7'd7:  script_word = op(cmd_powerb);
            7'd8:  script_word = arg(8'h00);
            7'd9:  script_word = arg(8'hC1);
            7'd10: script_word = arg(8'h30);
            7'd11: script_word = op(cmd_dtca);
            7'd12: script_word = arg(8'h85);
            7'd13: script_word = arg(8'h00);
            7'd14: script_word = arg(8'h78);
            7'd15: script_word = op(cmd_dtcb);
            7'd16: script_word = arg(8'h00);
            7'd17: script_word = arg(8'h00);
            7'd18: script_word = op(cmd_power_seq);
            7'd19: script_word = arg(8'h64);
            7'd20: script_word = arg(8'h03);
            7'd21: script_word = arg(8'h12);
            7'd22: script_word = arg(8'h81);
            7'd23: script_word = op(cmd_prc);
            7'd24: script_word = arg(8'h20);
            7'd25: script_word = op(cmd_pwctr1);
            7'd26: script_word = arg(8'h23);  // GVDD level
            7'd27: script_word = op(cmd_pwctr2);
            7'd28: script_word = arg(8'h10);
            7'd29: script_word = op(cmd_vmctr1);
            7'd30: script_word = arg(8'h3E);
            7'd31: script_word = arg(8'h28);
            7'd32: script_word = op(cmd_vmctr2);
            7'd33: script_word = arg(8'h86);
            7'd34: script_word = op(cmd_madctl);
            7'd35: script_word = arg(madctl_mx | madctl_bgr);  // Portrait
            7'd36: script_word = op(cmd_vscradd);
            7'd37: script_word = arg(8'h00);
            7'd38: script_word = op(cmd_colmod);
            7'd39: script_word = arg(8'h55);  // 16 bit per pixel
            7'd40: script_word = op(cmd_frmcrn1);
            7'd41: script_word = arg(8'h00);
            7'd42: script_word = arg(8'h18);
            7'd43: script_word = op(cmd_disctrl);
            7'd44: script_word = arg(8'h08);
            7'd45: script_word = arg(8'h82);
            7'd46: script_word = arg(8'h27);
            7'd47: script_word = op(cmd_gamma3_en);
            7'd48: script_word = arg(8'h00);  // 3-gamma off
            7'd49: script_word = op(cmd_gammaset);
            7'd50: script_word = arg(8'h01);
            7'd51: script_word = op(cmd_slpout);
            7'd52: script_word = op(cmd_dispon);
            // ------------------------------------------------------------
            // Rotation and full-screen window
            // ------------------------------------------------------------
            7'd53: script_word = op(cmd_madctl);
            7'd54: script_word = arg(madctl_mx | madctl_my | madctl_mv | madctl_bgr);
            7'd55: script_word = op(cmd_caset);
            7'd56: script_word = arg(8'h00);
            7'd57: script_word = arg(8'h00);
            7'd58: script_word = arg(8'h01);
            7'd59: script_word = arg(8'h3F);  // Column 319
            7'd60: script_word = op(cmd_paset);
            7'd61: script_word = arg(8'h00);
            7'd62: script_word = arg(8'h00);
            7'd63: script_word = arg(8'h00);
            7'd64: script_word = arg(8'hEF);  // Page 239
            7'd65: script_word = op(cmd_ramwr);
            default: script_word = '0;  // NOP
        endcase
    end

endmodule

//--- verilog/spi_master.sv
`timescale 1ns/1ps

module spi_master (
    input  logic                   clk,
    input  logic                   rst,
    input  lcd_ctrl_pkg::spi_req_t spi_req,
    output logic                   idle,
    output logic                   spi_mosi,
    output logic                   spi_sck,
    output logic                   spi_cs,
    output logic                   spi_dc
);
    import lcd_ctrl_pkg::*;

    logic                         busy;
    logic [byte_bits-1:0]         shift_reg;
    logic [$clog2(byte_bits)-1:0] bit_cnt;

    assign idle     = ~busy;
    assign spi_cs   = ~busy;
    assign spi_mosi = shift_reg[byte_bits-1];  // MSB first

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy    <= 1'b0;
            spi_sck <= 1'b0;
        end else if (!busy) begin
            if (spi_req.start) begin
                busy <= 1'b1;
            end
        end else if (!spi_sck) begin
            spi_sck <= 1'b1;  // Display samples here
        end else begin
            spi_sck <= 1'b0;
            if (bit_cnt == $clog2(byte_bits)'(byte_bits - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    // Payload and bit position
    always_ff @(posedge clk) begin
        if (!busy && spi_req.start) begin
            shift_reg <= spi_req.word.data;
            spi_dc    <= spi_req.word.dc;
            bit_cnt   <= '0;
        end else if (busy && spi_sck) begin
            shift_reg <= shift_reg << 1;  // Next bit while sck is low
            bit_cnt   <= bit_cnt + 1'b1;
        end
    end

    // Requesters may only strobe while the serializer is free
    a_start_when_idle : assert property (
        @(posedge clk) disable iff (!rst) spi_req.start |-> idle
    );

endmodule

//--- verilog/init_sequencer.sv
`timescale 1ns/1ps

module init_sequencer #(
    parameter int delay_cycles = 2500000
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      idle,
    input  logic                      frame_done,
    output lcd_ctrl_pkg::script_idx_t script_idx,
    input  lcd_ctrl_pkg::spi_word_t   script_word,
    output lcd_ctrl_pkg::spi_req_t    cmd_req,
    output logic                      stream_en
);
    import lcd_cmd_pkg::*;
    import lcd_ctrl_pkg::*;

    localparam int cnt_bits = $clog2(delay_cycles + 1);
    localparam logic [cnt_bits-1:0] delay_last = cnt_bits'(delay_cycles - 1);

    seq_state_t          state;
    seq_state_t          state_nxt;
    logic [cnt_bits-1:0] delay_cnt;
    script_idx_t         seg_last;    // Last word of the current segment
    script_idx_t         next_first;  // Index loaded when a wait ends
    logic                in_send;
    logic                in_wait;
    logic                seg_done;
    logic                delay_done;

    always_comb begin
        in_send    = 1'b1;
        in_wait    = 1'b0;
        seg_last   = '0;
        next_first = '0;
        case (state)
            send_reset:  seg_last = cfg_first - 7'd1;
            send_config: seg_last = cfg_last;
            send_dispon: seg_last = dispon_idx;
            send_window: seg_last = script_last;
            wait_reset: begin
                in_send    = 1'b0;
                in_wait    = 1'b1;
                next_first = cfg_first;
            end
            wait_config: begin
                in_send    = 1'b0;
                in_wait    = 1'b1;
                next_first = dispon_idx;
            end
            wait_dispon: begin
                in_send    = 1'b0;
                in_wait    = 1'b1;
                next_first = window_first;
            end
            default: in_send = 1'b0;
        endcase
    end

    assign seg_done   = idle & (script_idx == seg_last + 7'd1);  // Last word out, line free
    assign delay_done = (delay_cnt == delay_last);
    assign cmd_req    = '{start: in_send & idle & ~seg_done, word: script_word};
    assign stream_en  = (state == frame_loop);

    // ------------------------------------------------------------
    // Power-up FSM
    // ------------------------------------------------------------
    always_comb begin
        case (state)
            start:       state_nxt = send_reset;
            send_reset:  state_nxt = seg_done ? wait_reset : send_reset;
            wait_reset:  state_nxt = delay_done ? send_config : wait_reset;
            send_config: state_nxt = seg_done ? wait_config : send_config;
            wait_config: state_nxt = delay_done ? send_dispon : wait_config;
            send_dispon: state_nxt = seg_done ? wait_dispon : send_dispon;
            wait_dispon: state_nxt = delay_done ? send_window : wait_dispon;
            send_window: state_nxt = seg_done ? frame_loop : send_window;
            frame_loop:  state_nxt = frame_done ? wait_frame : frame_loop;
            wait_frame:  state_nxt = frame_done ? wait_frame : frame_loop;
            default:     state_nxt = start;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= start;
            script_idx <= '0;
            delay_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (cmd_req.start) begin
                script_idx <= script_idx + script_idx_t'(1);
            end else if (in_wait && delay_done) begin
                script_idx <= next_first;
            end
            if (in_wait && !delay_done) begin
                delay_cnt <= delay_cnt + 1'b1;
            end else begin
                delay_cnt <= '0;  // Restarts on every wait entry
            end
        end
    end

    a_idx_in_script : assert property (
        @(posedge clk) disable iff (!rst) cmd_req.start |-> (script_idx <= script_last)
    );

endmodule

//--- verilog/pixel_streamer.sv
`timescale 1ns/1ps

module pixel_streamer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stream_en,
    input  logic                   idle,
    input  lcd_ctrl_pkg::pixel_t   input_data,
    input  lcd_ctrl_pkg::spi_req_t cmd_req,
    output lcd_ctrl_pkg::spi_req_t spi_req,
    output logic                   data_clk
);
    import lcd_ctrl_pkg::*;

    logic                 low_phase;  // Next byte is the low byte
    logic [byte_bits-1:0] low_byte;   // Held since the source moves on
    logic                 launch;
    spi_req_t             pix_req;

    assign launch = stream_en & idle;

    always_comb begin
        pix_req.start   = launch;
        pix_req.word.dc = 1'b1;
        if (low_phase) begin
            pix_req.word.data = low_byte;
        end else begin
            pix_req.word.data = input_data[pixel_bits-1 -: byte_bits];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            low_phase <= 1'b0;
        end else if (!stream_en) begin
            low_phase <= 1'b0;  // Resume with a high byte
        end else if (idle) begin
            low_phase <= ~low_phase;
        end
    end

    always_ff @(posedge clk) begin
        if (launch && !low_phase) begin
            low_byte <= input_data[byte_bits-1:0];
        end
    end

    assign data_clk = low_phase;  // Rises once the high byte is out
    assign spi_req  = stream_en ? pix_req : cmd_req;

endmodule

//--- verilog/ili9341_controller.sv
`timescale 1ns/1ps

module ili9341_controller #(
    parameter int delay_cycles = 2500000  // About 100 ms per wait
) (
    input  logic                 clk,
    input  logic                 rst,
    input  lcd_ctrl_pkg::pixel_t input_data,
    input  logic                 frame_done,
    output logic                 spi_mosi,
    output logic                 spi_sck,
    output logic                 spi_cs,
    output logic                 spi_dc,
    output logic                 data_clk
);
    import lcd_ctrl_pkg::*;

    script_idx_t script_idx;
    spi_word_t   script_word;
    spi_req_t    cmd_req;
    spi_req_t    spi_req;
    logic        idle;
    logic        stream_en;

    init_rom u_init_rom (
        .script_idx  (script_idx),
        .script_word (script_word)
    );

    init_sequencer #(
        .delay_cycles (delay_cycles)
    ) u_init_sequencer (
        .clk         (clk),
        .rst         (rst),
        .idle        (idle),
        .frame_done  (frame_done),
        .script_idx  (script_idx),
        .script_word (script_word),
        .cmd_req     (cmd_req),
        .stream_en   (stream_en)
    );

    pixel_streamer u_pixel_streamer (
        .clk        (clk),
        .rst        (rst),
        .stream_en  (stream_en),
        .idle       (idle),
        .input_data (input_data),
        .cmd_req    (cmd_req),
        .spi_req    (spi_req),
        .data_clk   (data_clk)
    );

    spi_master u_spi_master (
        .clk      (clk),
        .rst      (rst),
        .spi_req  (spi_req),
        .idle     (idle),
        .spi_mosi (spi_mosi),
        .spi_sck  (spi_sck),
        .spi_cs   (spi_cs),
        .spi_dc   (spi_dc)
    );

endmodule

//--- bench/tb_ili9341_controller.sv
`timescale 1ns/1ps

module tb_ili9341_controller;
    import lcd_ctrl_pkg::*;

    localparam int delay_cycles  = 20;
    localparam int script_words  = 66;
    localparam int pixel_count   = 4;
    localparam int pattern_depth = script_words + pixel_count;
    localparam int clk_period    = 100;
    localparam int half_period   = clk_period / 2;
    localparam int word_timeout  = 400;  // One wait plus one transfer, with margin
    localparam int pause_cycles  = 60;   // Several word times

    typedef struct packed {
        spi_word_t   word;
        logic [31:0] first_cycle;  // spi_cs fell
        logic [31:0] last_cycle;   // spi_cs rose
    } capture_t;

    logic        clk;
    logic        rst;
    pixel_t      input_data;
    logic        frame_done;
    logic        spi_mosi;
    logic        spi_sck;
    logic        spi_cs;
    logic        spi_dc;
    logic        data_clk;

    logic [15:0] patterns [pattern_depth];
    capture_t    captured [$];
    logic [7:0]  shift_in;
    logic        dc_in;
    int          bit_count;
    logic        in_word;
    logic [31:0] fall_cycle;
    int          pixel_idx;
    int          rise_count;
    logic        data_clk_prev;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

    ili9341_controller #(
        .delay_cycles (delay_cycles)
    ) u_ili9341_controller (
        .clk        (clk),
        .rst        (rst),
        .input_data (input_data),
        .frame_done (frame_done),
        .spi_mosi   (spi_mosi),
        .spi_sck    (spi_sck),
        .spi_cs     (spi_cs),
        .spi_dc     (spi_dc),
        .data_clk   (data_clk)
    );

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic next_word(output capture_t cap);
        int waited;
        waited = 0;
        while (captured.size() == 0 && waited < word_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (captured.size() == 0) begin
            $display("timeout: no SPI word arrived within %0d cycles", word_timeout);
            abort_run();
        end else begin
            cap = captured.pop_front();
        end
    endtask

    task automatic wait_cs_low();
        int waited;
        waited = 0;
        while (spi_cs !== 1'b0 && waited < word_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (spi_cs !== 1'b0) begin
            $display("timeout: spi_cs did not fall for the high pixel byte");
            abort_run();
        end
    endtask

    task automatic hold_frame_pause();
        for (int c = 0; c < pause_cycles; c++) begin
            @(negedge clk);
            check_value("spi_cs during frame pause", 32'(spi_cs), 32'd1);
        end
        check_value("words captured during frame pause", 32'(captured.size()), 32'd0);
        frame_done = 1'b0;
    endtask

    // ------------------------------------------------------------
    // SPI capture
    // ------------------------------------------------------------
    always @(negedge spi_cs) begin
        if (rst) begin
            in_word    = 1'b1;
            bit_count  = 0;
            fall_cycle = 32'($time / clk_period);
        end
    end

    always @(posedge spi_sck) begin
        if (in_word) begin
            shift_in = {shift_in[6:0], spi_mosi};  // MSB arrives first
            dc_in    = spi_dc;
            bit_count++;
        end
    end

    always @(posedge spi_cs) begin : collect_word
        capture_t cap;
        if (in_word) begin
            in_word = 1'b0;
            check_value("bits per word on spi_mosi", 32'(bit_count), 32'd8);
            cap.word.dc     = dc_in;
            cap.word.data   = shift_in;
            cap.first_cycle = fall_cycle;
            cap.last_cycle  = 32'($time / clk_period);
            captured.push_back(cap);
        end
    end

    // Pixel source, advances once the high byte is launched
    always @(negedge clk) begin
        if (rst && data_clk === 1'b1 && data_clk_prev === 1'b0) begin
            rise_count++;
            pixel_idx  = (pixel_idx + 1) % pixel_count;
            input_data = patterns[script_words + pixel_idx];
        end
        data_clk_prev = data_clk;
    end

    initial begin
        capture_t    cap;
        capture_t    prev;
        logic [31:0] gap;
        pixel_t      pixel;
        in_word       = 1'b0;
        bit_count     = 0;
        pixel_idx     = 0;
        rise_count    = 0;
        data_clk_prev = 1'b0;
        $readmemh("bench/ili9341_patterns.hex", patterns);
        rst        = 1'b0;
        frame_done = 1'b0;
        input_data = patterns[script_words];
        prev       = '0;

        // Three reset cycles, then the first cycle after release
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_value("spi_cs", 32'(spi_cs), 32'd1);
            check_value("spi_sck", 32'(spi_sck), 32'd0);
            check_value("data_clk", 32'(data_clk), 32'd0);
            if (c == 2) begin
                rst = 1'b1;
            end
        end

        // ------------------------------------------------------------
        // Power-up script
        // ------------------------------------------------------------
        for (int i = 0; i < script_words; i++) begin
            next_word(cap);
            check_value($sformatf("spi_dc of script word %0d", i),
                        32'(cap.word.dc), 32'(patterns[i][8]));
            check_value($sformatf("spi_mosi byte of script word %0d", i),
                        32'(cap.word.data), 32'(patterns[i][7:0]));
            if (i == 1 || i == 52 || i == 53) begin  // Words that follow a wait
                gap = cap.first_cycle - prev.last_cycle;
                check_value($sformatf("spi_cs gap of %0d cycles before word %0d covers the wait",
                                      gap, i),
                            32'(gap >= 32'(delay_cycles)), 32'd1);
            end
            prev = cap;
        end

        // ------------------------------------------------------------
        // Pixel stream with one frame pause
        // ------------------------------------------------------------
        for (int p = 0; p < pixel_count; p++) begin
            pixel = patterns[script_words + p];
            if (p == 1) begin
                wait_cs_low();  // Pause lands during the high byte
                frame_done = 1'b1;
            end
            next_word(cap);
            check_value($sformatf("spi_dc of pixel %0d high byte", p),
                        32'(cap.word.dc), 32'd1);
            check_value($sformatf("spi_mosi of pixel %0d high byte", p),
                        32'(cap.word.data), 32'(pixel[15:8]));
            if (p == 1) begin
                check_value("data_clk rising edges", 32'(rise_count), 32'(p + 1));
                hold_frame_pause();  // Byte phase restarts, this low byte is never sent
            end else begin
                next_word(cap);
                check_value($sformatf("spi_dc of pixel %0d low byte", p),
                            32'(cap.word.dc), 32'd1);
                check_value($sformatf("spi_mosi of pixel %0d low byte", p),
                            32'(cap.word.data), 32'(pixel[7:0]));
                check_value("data_clk rising edges", 32'(rise_count), 32'(p + 1));
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- bench/ili9341_patterns.hex
// Entries 0 to 65: expected SPI words, bit 8 is dc and bits 7:0 the byte
// Entries 66 to 69: RGB565 pixels driven on input_data
001  // SWRESET
0CB
139
12C
100
134
102
0CF
100
1C1
130
0E8
185
100
178
0EA
100
100
0ED
164
103
112
181
0F7
120
0C0
123
0C1
110
0C5
13E
128
0C7
186
036
148
037
100
03A
155  // 16 bit per pixel
0B1
100
118
0B6
108
182
127
0F2
100
026
101
011  // SLPOUT
029  // DISPON
036
1E8  // MX MY MV BGR
02A
100
100
101
13F
02B
100
100
100
1EF
02C  // RAMWR
F800
07E0
001F
5AA5

//--- sim.f
verilog/lcd_cmd_pkg.sv
verilog/lcd_ctrl_pkg.sv
verilog/init_rom.sv
verilog/spi_master.sv
verilog/init_sequencer.sv
verilog/pixel_streamer.sv
verilog/ili9341_controller.sv
bench/tb_ili9341_controller.sv

//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tb_ili9341_controller
FILELIST  := sim.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "TB FAILED" $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
